// File: source/id_consts.svh
/* Opcode, funct and ALU operation codes plus register-file sizes for the decode stage.
   Include wherever these constants are needed. */
`ifndef ID_CONSTS_SVH
`define ID_CONSTS_SVH

`define ID_XLEN         64
`define ID_REG_COUNT    32

// ------------------------------------------------------------
// Major opcodes
// ------------------------------------------------------------
`define ID_OPC_LUI      7'b0110111
`define ID_OPC_AUIPC    7'b0010111
`define ID_OPC_JAL      7'b1101111
`define ID_OPC_JALR     7'b1100111
`define ID_OPC_BRANCH   7'b1100011
`define ID_OPC_LOAD     7'b0000011
`define ID_OPC_STORE    7'b0100011
`define ID_OPC_OP_IMM   7'b0010011
`define ID_OPC_OP_IMM32 7'b0011011
`define ID_OPC_OP       7'b0110011
`define ID_OPC_OP32     7'b0111011

// Branch conditions
`define ID_F3_BEQ       3'b000
`define ID_F3_BNE       3'b001
`define ID_F3_BLT       3'b100
`define ID_F3_BGE       3'b101
`define ID_F3_BLTU      3'b110
`define ID_F3_BGEU      3'b111

// SUB and SRA
`define ID_F7_ALT       7'b0100000

// ------------------------------------------------------------
// ALU operations
// ------------------------------------------------------------
`define ID_ALU_ADD      4'd0
`define ID_ALU_SUB      4'd1
`define ID_ALU_SLT      4'd2
`define ID_ALU_SLTU     4'd3
`define ID_ALU_AND      4'd4
`define ID_ALU_OR       4'd5
`define ID_ALU_XOR      4'd6
`define ID_ALU_SLL      4'd7
`define ID_ALU_SRL      4'd8
`define ID_ALU_SRA      4'd9

`endif

// File: source/id_pkg.sv
/* Types shared by the decode stage and its neighbours.
   Import with a wildcard in the module header. */
`include "id_consts.svh"

package id_pkg;

    typedef logic [`ID_XLEN-1:0] xlen_t;
    typedef logic [31:0]         inst_t;
    typedef logic [4:0]          reg_addr_t;
    typedef logic [3:0]          alu_op_t;
    // 0 byte, 1 half, 2 word, 3 double
    typedef logic [1:0]          mem_size_t;

    typedef struct packed {
        inst_t inst;
        xlen_t pc;
    } fetch_pkt_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        xlen_t     wdata;
    } wb_pkt_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        xlen_t     data;
    } fwd_pkt_t;

    typedef struct packed {
        fwd_pkt_t fwd;
        logic     is_load;
    } ex_fwd_pkt_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      src_pc;
        logic      src_imm;
        logic      src_4;
        logic      src_zero;
        logic      src_shamt;
        logic      rf_we;
        logic      mem_we;
        logic      mem_re;
        mem_size_t mem_size;
        logic      res_sext;
        logic      res_zext;
    } ctrl_t;

    // Branch class handed from decoder to branch unit
    typedef struct packed {
        logic [2:0] funct3;
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
    } br_kind_t;

    typedef struct packed {
        ctrl_t     ctrl;
        reg_addr_t rd;
        xlen_t     imm;
        xlen_t     rs1_value;
        xlen_t     rs2_value;
        xlen_t     pc;
    } de_pkt_t;

    typedef struct packed {
        logic  taken;
        xlen_t target;
    } br_pkt_t;

endpackage

// File: source/stage_latch.sv
/* Pipeline register between fetch and decode.
   Holds one instruction and produces the allow-in and output valid of the stage. */
`timescale 1ns/10ps

module stage_latch import id_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       in_valid,
    input  fetch_pkt_t fetch,
    input  logic       out_ready,
    input  logic       stall,
    input  logic       flush,
    output logic       in_ready,
    output logic       out_valid,
    output logic       valid,
    output fetch_pkt_t held
);

    // Empty, or the held instruction leaves this cycle
    assign in_ready = !valid || (!stall && out_ready);

    assign out_valid = valid && !stall && !flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (in_ready) begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            held <= fetch;
        end
    end

endmodule

// File: source/inst_decoder.sv
/* RV64I instruction decoder: register fields, immediates and control flags.
   Purely combinational, fed from the decode latch. */
`timescale 1ns/10ps
`include "id_consts.svh"

module inst_decoder import id_pkg::*; (
    input  inst_t     inst,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output reg_addr_t rd,
    output xlen_t     imm,
    output ctrl_t     ctrl,
    output br_kind_t  br_kind,
    output xlen_t     b_off,
    output xlen_t     j_off
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt_f7;
    logic       alt_f6;
    xlen_t      imm_i, imm_s, imm_u;

    // funct3 to ALU operation, alt picks SUB / SRA
    function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  alu_sel = alt ? `ID_ALU_SUB : `ID_ALU_ADD;
            3'b001:  alu_sel = `ID_ALU_SLL;
            3'b010:  alu_sel = `ID_ALU_SLT;
            3'b011:  alu_sel = `ID_ALU_SLTU;
            3'b100:  alu_sel = `ID_ALU_XOR;
            3'b101:  alu_sel = alt ? `ID_ALU_SRA : `ID_ALU_SRL;
            3'b110:  alu_sel = `ID_ALU_OR;
            default: alu_sel = `ID_ALU_AND;
        endcase
    endfunction

    // ------------------------------------------------------------
    // Fields and immediates
    // ------------------------------------------------------------
    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign funct7 = inst[31:25];

    assign alt_f7 = funct7 == `ID_F7_ALT;
    // 64-bit shifts use funct7[0] as shamt[5]
    assign alt_f6 = {funct7[6:1], 1'b0} == `ID_F7_ALT;

    assign imm_i = {{(`ID_XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_s = {{(`ID_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_u = {{(`ID_XLEN-32){inst[31]}}, inst[31:12], 12'b0};
    assign b_off = {{(`ID_XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                    inst[11:8], 1'b0};
    assign j_off = {{(`ID_XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                    inst[30:21], 1'b0};

    assign br_kind = '{funct3: funct3,
                       is_branch: opcode == `ID_OPC_BRANCH,
                       is_jal: opcode == `ID_OPC_JAL,
                       is_jalr: opcode == `ID_OPC_JALR};

    // ------------------------------------------------------------
    // Control
    // ------------------------------------------------------------
    always_comb begin
        ctrl = '0;
        ctrl.alu_op = `ID_ALU_ADD;
        imm = '0;
        case (opcode)
            `ID_OPC_LUI: begin
                ctrl.src_zero = 1'b1;
                ctrl.src_imm  = 1'b1;
                ctrl.rf_we    = 1'b1;
                imm = imm_u;
            end
            `ID_OPC_AUIPC: begin
                ctrl.src_pc  = 1'b1;
                ctrl.src_imm = 1'b1;
                ctrl.rf_we   = 1'b1;
                imm = imm_u;
            end
            `ID_OPC_JAL, `ID_OPC_JALR: begin
                // Link value is pc + 4
                ctrl.src_pc = 1'b1;
                ctrl.src_4  = 1'b1;
                ctrl.rf_we  = 1'b1;
                imm = (opcode == `ID_OPC_JAL) ? j_off : imm_i;
            end
            `ID_OPC_BRANCH: begin
                imm = b_off;
            end
            `ID_OPC_LOAD: begin
                ctrl.src_imm  = 1'b1;
                ctrl.rf_we    = 1'b1;
                ctrl.mem_re   = 1'b1;
                ctrl.mem_size = funct3[1:0];
                ctrl.res_sext = !funct3[2];
                ctrl.res_zext = funct3[2];
                imm = imm_i;
            end
            `ID_OPC_STORE: begin
                ctrl.src_imm  = 1'b1;
                ctrl.mem_we   = 1'b1;
                ctrl.mem_size = funct3[1:0];
                imm = imm_s;
            end
            `ID_OPC_OP_IMM, `ID_OPC_OP_IMM32: begin
                ctrl.src_imm   = 1'b1;
                ctrl.rf_we     = 1'b1;
                ctrl.src_shamt = funct3[1:0] == 2'b01;
                ctrl.res_sext  = opcode == `ID_OPC_OP_IMM32;
                if (opcode == `ID_OPC_OP_IMM) begin
                    ctrl.alu_op = alu_sel(funct3, funct3 == 3'b101 && alt_f6);
                end else begin
                    ctrl.alu_op = alu_sel(funct3, funct3 == 3'b101 && alt_f7);
                end
                imm = imm_i;
            end
            `ID_OPC_OP, `ID_OPC_OP32: begin
                ctrl.rf_we    = 1'b1;
                ctrl.res_sext = opcode == `ID_OPC_OP32;
                ctrl.alu_op   = alu_sel(funct3, alt_f7);
            end
            default: begin
                ctrl.rf_we = 1'b0;
            end
        endcase
    end

endmodule

// File: source/reg_file.sv
/* Integer register file, two combinational read ports and one write port.
   Written from the write-back stage; x0 is hardwired to zero. */
`timescale 1ns/10ps
`include "id_consts.svh"

module reg_file import id_pkg::*; (
    input  logic      clk,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    input  wb_pkt_t   wb,
    output xlen_t     rdata1,
    output xlen_t     rdata2
);

    xlen_t regs [`ID_REG_COUNT];

    always_ff @(posedge clk) begin
        if (wb.we && wb.waddr != '0) begin
            regs[wb.waddr] <= wb.wdata;
        end
    end

    // No write-through; same-cycle writes come in over wb_fwd
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: source/operand_forward.sv
/* Operand bypass from execute, memory and write-back, plus load-use detection.
   Combinational; the stall goes to the decode latch. */
`timescale 1ns/10ps

module operand_forward import id_pkg::*; (
    input  reg_addr_t   rs1,
    input  reg_addr_t   rs2,
    input  xlen_t       rdata1,
    input  xlen_t       rdata2,
    input  ex_fwd_pkt_t ex_fwd,
    input  fwd_pkt_t    mem_fwd,
    input  fwd_pkt_t    wb_fwd,
    output xlen_t       rs1_value,
    output xlen_t       rs2_value,
    output logic        stall
);

    logic ex_hit1, ex_hit2;

    function automatic logic hit(input fwd_pkt_t stage, input reg_addr_t src);
        hit = stage.valid && src != '0 && stage.rd == src;
    endfunction

    // Youngest producer wins
    function automatic xlen_t pick(input reg_addr_t src, input xlen_t rf_value,
                                   input ex_fwd_pkt_t ex, input fwd_pkt_t mem,
                                   input fwd_pkt_t wbk);
        if (hit(ex.fwd, src)) begin
            pick = ex.fwd.data;
        end else if (hit(mem, src)) begin
            pick = mem.data;
        end else if (hit(wbk, src)) begin
            pick = wbk.data;
        end else begin
            pick = rf_value;
        end
    endfunction

    assign rs1_value = pick(rs1, rdata1, ex_fwd, mem_fwd, wb_fwd);
    assign rs2_value = pick(rs2, rdata2, ex_fwd, mem_fwd, wb_fwd);

    assign ex_hit1 = hit(ex_fwd.fwd, rs1);
    assign ex_hit2 = hit(ex_fwd.fwd, rs2);

    // Load data is not ready until memory
    assign stall = ex_fwd.is_load && (ex_hit1 || ex_hit2);

endmodule

// File: source/branch_unit.sv
/* Branch and jump resolution in decode.
   Compares the forwarded operands and forms the redirect target. */
`timescale 1ns/10ps
`include "id_consts.svh"

module branch_unit import id_pkg::*; (
    input  logic     valid,
    input  br_kind_t br_kind,
    input  xlen_t    rs1_value,
    input  xlen_t    rs2_value,
    input  xlen_t    pc,
    input  xlen_t    imm,
    input  xlen_t    b_off,
    input  xlen_t    j_off,
    output br_pkt_t  br
);

    logic eq, lt, ltu;
    logic cond;

    assign eq  = rs1_value == rs2_value;
    assign lt  = $signed(rs1_value) < $signed(rs2_value);
    assign ltu = rs1_value < rs2_value;

    always_comb begin
        case (br_kind.funct3)
            `ID_F3_BEQ:  cond = eq;
            `ID_F3_BNE:  cond = !eq;
            `ID_F3_BLT:  cond = lt;
            `ID_F3_BGE:  cond = !lt;
            `ID_F3_BLTU: cond = ltu;
            `ID_F3_BGEU: cond = !ltu;
            default:     cond = 1'b0;
        endcase
    end

    assign br.taken = valid && ((br_kind.is_branch && cond) || br_kind.is_jal
                                || br_kind.is_jalr);

    // JALR is register relative, everything else PC relative
    assign br.target = br_kind.is_jalr   ? rs1_value + imm :
                       br_kind.is_branch ? pc + b_off :
                                           pc + j_off;

endmodule

// File: source/id_stage.sv
/* Instruction decode stage of the RV64I pipeline.
   Sits between fetch and execute with valid/ready handshakes on both sides. */
`timescale 1ns/10ps

module id_stage import id_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    input  fetch_pkt_t  fetch,
    output logic        in_ready,
    output logic        out_valid,
    input  logic        out_ready,
    output de_pkt_t     de,
    output br_pkt_t     br,
    input  wb_pkt_t     wb,
    input  ex_fwd_pkt_t ex_fwd,
    input  fwd_pkt_t    mem_fwd,
    input  fwd_pkt_t    wb_fwd,
    input  logic        flush
);

    logic       valid;
    logic       stall;
    fetch_pkt_t held;
    reg_addr_t  rs1, rs2, rd;
    xlen_t      imm, b_off, j_off;
    ctrl_t      ctrl;
    br_kind_t   br_kind;
    xlen_t      rdata1, rdata2;
    xlen_t      rs1_value, rs2_value;

    stage_latch latch_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .fetch     (fetch),
        .out_ready (out_ready),
        .stall     (stall),
        .flush     (flush),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .valid     (valid),
        .held      (held)
    );

    inst_decoder decoder_i (
        .inst    (held.inst),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .imm     (imm),
        .ctrl    (ctrl),
        .br_kind (br_kind),
        .b_off   (b_off),
        .j_off   (j_off)
    );

    reg_file rf_i (
        .clk    (clk),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .wb     (wb),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    operand_forward fwd_i (
        .rs1       (rs1),
        .rs2       (rs2),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .ex_fwd    (ex_fwd),
        .mem_fwd   (mem_fwd),
        .wb_fwd    (wb_fwd),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .stall     (stall)
    );

    branch_unit branch_i (
        .valid     (valid),
        .br_kind   (br_kind),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .pc        (held.pc),
        .imm       (imm),
        .b_off     (b_off),
        .j_off     (j_off),
        .br        (br)
    );

    assign de = '{ctrl: ctrl, rd: rd, imm: imm, rs1_value: rs1_value,
                  rs2_value: rs2_value, pc: held.pc};

endmodule

// File: tests/tb_id_stage.sv
/* Self-checking testbench for the decode stage.
   Drives fetch, forward and write-back inputs and checks the outputs with assertions. */
`timescale 1ns/10ps
`include "id_consts.svh"

module tb_id_stage import id_pkg::*; ();

    logic        clk;
    logic        reset;
    logic        in_valid;
    fetch_pkt_t  fetch;
    logic        in_ready;
    logic        out_valid;
    logic        out_ready;
    de_pkt_t     de;
    br_pkt_t     br;
    wb_pkt_t     wb;
    ex_fwd_pkt_t ex_fwd;
    fwd_pkt_t    mem_fwd;
    fwd_pkt_t    wb_fwd;
    logic        flush;

    int checks = 0;
    int errors = 0;
    int timeouts = 0;

    id_stage dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #200000;
        $display("Simulation stopped by the watchdog");
        $display("RESULT: FAIL");
        $finish;
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    task automatic check(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("ERROR %0t: %s", $time, what);
        end
    endtask

    function automatic inst_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t enc_b(input logic [12:0] off, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `ID_OPC_BRANCH};
    endfunction

    function automatic inst_t enc_j(input logic [20:0] off, input reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, `ID_OPC_JAL};
    endfunction

    // Loads one instruction into the latch and returns on the next falling edge
    task automatic issue(input inst_t inst, input xlen_t pc);
        int n;
        @(negedge clk);
        in_valid = 1'b1;
        fetch = '{inst: inst, pc: pc};
        ex_fwd = '0;
        mem_fwd = '0;
        wb_fwd = '0;
        n = 0;
        #1;
        while (!in_ready && n < 20) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (!in_ready) begin
            timeouts++;
            $display("Timed out waiting for in_ready at %0t", $time);
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic write_reg(input reg_addr_t addr, input xlen_t data);
        @(negedge clk);
        wb = '{we: 1'b1, waddr: addr, wdata: data};
        @(negedge clk);
        wb.we = 1'b0;
    endtask

    task automatic check_decode(input inst_t inst, input ctrl_t exp_ctrl,
                                input reg_addr_t exp_rd, input xlen_t exp_imm,
                                input logic has_imm, input string name);
        issue(inst, 64'h1000);
        #5;
        check(de.ctrl == exp_ctrl, {name, " control fields"});
        check(de.rd == exp_rd, {name, " rd"});
        if (has_imm) begin
            check(de.imm == exp_imm, $sformatf("%s imm %h", name, de.imm));
        end
    endtask

    task automatic branch_case(input logic [2:0] f3);
        xlen_t       a, b, pc;
        logic [12:0] off;
        logic        exp_taken;
        a = {$urandom, $urandom};
        b = ($urandom % 3 == 0) ? a : {$urandom, $urandom};
        off = 13'($urandom) & 13'h1ffe;
        pc = {32'h0, $urandom} & ~64'h3;
        issue(enc_b(off, 5'd12, 5'd11, f3), pc);
        mem_fwd = '{valid: 1'b1, rd: 5'd11, data: a};
        wb_fwd = '{valid: 1'b1, rd: 5'd12, data: b};
        #5;
        case (f3)
            `ID_F3_BEQ:  exp_taken = a == b;
            `ID_F3_BNE:  exp_taken = a != b;
            `ID_F3_BLT:  exp_taken = $signed(a) < $signed(b);
            `ID_F3_BGE:  exp_taken = $signed(a) >= $signed(b);
            `ID_F3_BLTU: exp_taken = a < b;
            default:     exp_taken = a >= b;
        endcase
        check(br.taken === exp_taken, $sformatf("branch f3=%0d taken", f3));
        check(br.target === pc + {{51{off[12]}}, off}, $sformatf("branch f3=%0d target", f3));
    endtask

    // Handshake rules sampled mid cycle
    always @(negedge clk) begin
        #10;
        if (!reset && flush) begin
            check(!out_valid, "out_valid high during flush");
        end
        if (!reset && !out_ready && out_valid) begin
            check(!in_ready, "in_ready high under back-pressure");
        end
    end

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial begin
        logic [20:0] joff;
        logic [11:0] ioff;
        xlen_t       a;
        void'($urandom(32'ha0be_9d54));
        reset = 1'b1;
        in_valid = 1'b0;
        fetch = '0;
        out_ready = 1'b1;
        wb = '0;
        ex_fwd = '0;
        mem_fwd = '0;
        wb_fwd = '0;
        flush = 1'b0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        #5;
        check(!out_valid && in_ready && !br.taken, "state after reset");

        // Control fields in order alu, pc, imm, 4, zero, shamt, rf_we, mem_we, mem_re, size, sext, zext
        check_decode(enc_i(12'hffb, 5'd4, 3'b000, 5'd3, `ID_OPC_OP_IMM),
                     '{`ID_ALU_ADD, 0, 1, 0, 0, 0, 1, 0, 0, 0, 0, 0}, 5'd3,
                     64'hffff_ffff_ffff_fffb, 1'b1, "ADDI");
        check_decode(enc_r(`ID_F7_ALT, 5'd8, 5'd7, 3'b000, 5'd6, `ID_OPC_OP),
                     '{`ID_ALU_SUB, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0}, 5'd6,
                     '0, 1'b0, "SUB");
        check_decode(enc_i({`ID_F7_ALT, 5'd3}, 5'd10, 3'b101, 5'd9, `ID_OPC_OP_IMM32),
                     '{`ID_ALU_SRA, 0, 1, 0, 0, 1, 1, 0, 0, 0, 1, 0}, 5'd9,
                     64'h403, 1'b1, "SRAIW");
        check_decode(enc_i(12'd16, 5'd12, 3'b100, 5'd11, `ID_OPC_LOAD),
                     '{`ID_ALU_ADD, 0, 1, 0, 0, 0, 1, 0, 1, 0, 0, 1}, 5'd11,
                     64'd16, 1'b1, "LBU");
        check_decode({7'h7f, 5'd13, 5'd14, 3'b011, 5'h18, `ID_OPC_STORE},
                     '{`ID_ALU_ADD, 0, 1, 0, 0, 0, 0, 1, 0, 3, 0, 0}, 5'h18,
                     64'hffff_ffff_ffff_fff8, 1'b1, "SD");
        check_decode({20'habcde, 5'd15, `ID_OPC_LUI},
                     '{`ID_ALU_ADD, 0, 1, 0, 1, 0, 1, 0, 0, 0, 0, 0}, 5'd15,
                     64'hffff_ffff_abcd_e000, 1'b1, "LUI");
        check_decode({20'h12345, 5'd16, `ID_OPC_AUIPC},
                     '{`ID_ALU_ADD, 1, 1, 0, 0, 0, 1, 0, 0, 0, 0, 0}, 5'd16,
                     64'h1234_5000, 1'b1, "AUIPC");

        // Register file
        write_reg(5'd5, 64'h0123_4567_89ab_cdef);
        write_reg(5'd7, 64'h7777_0000_7777_0000);
        write_reg(5'd0, 64'hdead_beef_dead_beef);
        issue(enc_r(7'd0, 5'd7, 5'd5, 3'b000, 5'd1, `ID_OPC_OP), 64'h2000);
        #5;
        check(de.rs1_value == 64'h0123_4567_89ab_cdef, "register x5 readback");
        check(de.rs2_value == 64'h7777_0000_7777_0000, "register x7 readback");
        issue(enc_i(12'd0, 5'd0, 3'b000, 5'd1, `ID_OPC_OP_IMM), 64'h2004);
        #5;
        check(de.rs1_value == '0, "x0 not zero");

        // Forwarding priority
        issue(enc_r(7'd0, 5'd0, 5'd7, 3'b000, 5'd1, `ID_OPC_OP), 64'h3000);
        ex_fwd = '{fwd: '{valid: 1'b1, rd: 5'd7, data: 64'haaaa}, is_load: 1'b0};
        mem_fwd = '{valid: 1'b1, rd: 5'd7, data: 64'hbbbb};
        wb_fwd = '{valid: 1'b1, rd: 5'd7, data: 64'hcccc};
        #5;
        check(de.rs1_value == 64'haaaa, "execute stage not chosen");
        @(negedge clk);
        ex_fwd.fwd.valid = 1'b0;
        #5;
        check(de.rs1_value == 64'hbbbb, "memory stage not chosen");
        @(negedge clk);
        mem_fwd.valid = 1'b0;
        #5;
        check(de.rs1_value == 64'hcccc, "write-back stage not chosen");
        @(negedge clk);
        wb_fwd.valid = 1'b0;
        #5;
        check(de.rs1_value == 64'h7777_0000_7777_0000, "register file not chosen");
        issue(enc_r(7'd0, 5'd0, 5'd0, 3'b000, 5'd1, `ID_OPC_OP), 64'h3004);
        ex_fwd = '{fwd: '{valid: 1'b1, rd: 5'd0, data: 64'h1111}, is_load: 1'b0};
        mem_fwd = '{valid: 1'b1, rd: 5'd0, data: 64'h2222};
        wb_fwd = '{valid: 1'b1, rd: 5'd0, data: 64'h3333};
        #5;
        check(de.rs1_value == '0, "x0 forwarded");

        // Load-use stall
        issue(enc_r(7'd0, 5'd9, 5'd3, 3'b000, 5'd2, `ID_OPC_OP), 64'h4000);
        ex_fwd = '{fwd: '{valid: 1'b1, rd: 5'd9, data: 64'h5a5a}, is_load: 1'b1};
        #5;
        check(!out_valid && !in_ready, "no stall on load-use");
        @(negedge clk);
        ex_fwd.is_load = 1'b0;
        #5;
        check(out_valid && in_ready, "stall not released");
        check(de.rs2_value == 64'h5a5a, "forwarded rs2 after stall");

        // Branches and jumps
        for (int k = 0; k < 4; k++) begin
            branch_case(`ID_F3_BEQ);
            branch_case(`ID_F3_BNE);
            branch_case(`ID_F3_BLT);
            branch_case(`ID_F3_BGE);
            branch_case(`ID_F3_BLTU);
            branch_case(`ID_F3_BGEU);
        end
        joff = 21'($urandom) & 21'h1ffffe;
        issue(enc_j(joff, 5'd1), 64'h8000);
        #5;
        check(br.taken && br.target == 64'h8000 + {{43{joff[20]}}, joff}, "JAL");
        ioff = 12'($urandom);
        a = {$urandom, $urandom};
        issue(enc_i(ioff, 5'd11, 3'b000, 5'd1, `ID_OPC_JALR), 64'h9000);
        mem_fwd = '{valid: 1'b1, rd: 5'd11, data: a};
        #5;
        check(br.taken && br.target == a + {{52{ioff[11]}}, ioff}, "JALR");
        @(negedge clk);
        #5;
        check(!br.taken, "taken with empty latch");

        // Back-pressure and flush
        @(negedge clk);
        out_ready = 1'b0;
        issue(enc_i(12'd1, 5'd1, 3'b000, 5'd1, `ID_OPC_OP_IMM), 64'ha000);
        #5;
        check(out_valid && !in_ready, "valid under back-pressure");
        @(negedge clk);
        in_valid = 1'b1;
        fetch = '{inst: enc_i(12'd2, 5'd1, 3'b000, 5'd1, `ID_OPC_OP_IMM), pc: 64'hb000};
        repeat (2) @(negedge clk);
        #5;
        check(!in_ready && de.pc == 64'ha000, "held packet changed");
        @(negedge clk);
        flush = 1'b1;
        #5;
        check(!out_valid, "flush ignored");
        @(negedge clk);
        flush = 1'b0;
        #5;
        check(out_valid, "out_valid lost after flush");
        @(negedge clk);
        out_ready = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
        #5;
        check(de.pc == 64'hb000, "next packet not accepted");

        repeat (2) @(negedge clk);
        $display("checks=%0d errors=%0d timeouts=%0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+source
source/id_pkg.sv
source/stage_latch.sv
source/inst_decoder.sv
source/reg_file.sv
source/operand_forward.sv
source/branch_unit.sv
source/id_stage.sv
tests/tb_id_stage.sv

// File: Bender.yml
package:
  name: id_stage

export_include_dirs:
  - source

sources:
  - files:
      - source/id_pkg.sv
      - source/stage_latch.sv
      - source/inst_decoder.sv
      - source/reg_file.sv
      - source/operand_forward.sv
      - source/branch_unit.sv
      - source/id_stage.sv
  - target: test
    files:
      - tests/tb_id_stage.sv
